//--- fftPkg.sv
//////////////////////////////////////////////////
// Transform sizes and data formats for the 32-point FFT
// Samples and twiddles are signed Q1.15 words
// Address pairs are packed a over b
//////////////////////////////////////////////////

package fftPkg;

    // Transform geometry
    localparam int FftPoints           = 32;
    localparam int FftStages           = 5;
    localparam int ButterfliesPerStage = 16;
    localparam int AddrWidth           = 5;

    // Fixed-point word and multiplier sizes
    localparam int SampleWidth  = 16;
    localparam int ProductWidth = 36;
    // Low bit of the kept product slice, drops the Q1.15 fraction growth
    localparam int ProductLsb   = 15;

    // Twiddle ROM image, real parts first then imaginary parts
    localparam string TwiddleFile = "twiddleTable.hex";

    typedef logic signed [SampleWidth-1:0] sample_t;

    // One complex memory word
    typedef struct packed {
        sample_t re;
        sample_t im;
    } complex_t;

    // Butterfly address pair
    typedef struct packed {
        logic [AddrWidth-1:0] a;
        logic [AddrWidth-1:0] b;
    } addrPair_t;

endpackage

//--- capturePkg.sv
//////////////////////////////////////////////////
// Sampling and display constants
// One sample every SamplePeriod clocks, LEDs show bins 0 to 15
//////////////////////////////////////////////////

package capturePkg;

    // Clock cycles between two samples
    localparam int SamplePeriod = 64;

    // Levels stored for a high and a low input
    localparam int SampleHigh = 1023;
    localparam int SampleLow  = -1024;

    // LED bar, one LED per displayed bin
    localparam int LedCount    = 16;
    localparam int LedBinWidth = 4;

endpackage

//--- sampleCounter.sv
//////////////////////////////////////////////////
// Samples data once per SamplePeriod and loads 32 words
// Strobes between the 33rd strobe and done are dropped
//////////////////////////////////////////////////
`timescale 1ns/10ps

module sampleCounter
    import fftPkg::*;
    import capturePkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 data,
    input  logic                 done,
    output logic                 loadWrite,
    output logic                 start,
    output logic [AddrWidth-1:0] loadAddr,
    output complex_t             loadData
);

    localparam int TimerWidth = $clog2(SamplePeriod);
    localparam logic [TimerWidth-1:0] TimerLast = TimerWidth'(SamplePeriod - 1);
    // Count value at which the frame is full and start fires
    localparam logic [AddrWidth:0] StartCount = (AddrWidth + 1)'(FftPoints);

    logic [TimerWidth-1:0] timer;
    logic [AddrWidth:0]    frameCount;
    logic                  strobe;

    // Sample strobe timer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            timer <= '0;
        end else if (strobe) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    assign strobe = (timer == TimerLast);

    // Frame counter, parks one past StartCount until the FFT reports done
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frameCount <= '0;
        end else if (done) begin
            frameCount <= '0;
        end else if (strobe && frameCount <= StartCount) begin
            frameCount <= frameCount + 1'b1;
        end
    end

    assign loadWrite = strobe && (frameCount < StartCount);
    assign start     = strobe && (frameCount == StartCount);
    assign loadAddr  = frameCount[AddrWidth-1:0];

    // Real input only
    assign loadData.re = data ? sample_t'(SampleHigh) : sample_t'(SampleLow);
    assign loadData.im = '0;

endmodule

//--- fftSequencer.sv
//////////////////////////////////////////////////
// Address generator for the in-place radix-2 DIT FFT
// Two cycles per butterfly, done 162 cycles after start
// start is only taken in WAIT
//////////////////////////////////////////////////
`timescale 1ns/10ps

module fftSequencer
    import fftPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    output addrPair_t            addrs,
    output logic [AddrWidth-1:0] twiddleAddr,
    output logic                 writeEn,
    output logic                 bankSel,
    output logic                 lastStage,
    output logic                 clear,
    output logic                 done
);

    localparam int StageWidth = $clog2(FftStages);
    localparam int FlyWidth   = $clog2(ButterfliesPerStage);
    localparam logic [StageWidth-1:0] LastStageIdx = StageWidth'(FftStages - 1);
    localparam logic [FlyWidth-1:0]   LastFly      = FlyWidth'(ButterfliesPerStage - 1);
    // CLEAR, one READ and WRITE pair per butterfly, then DONE
    localparam int DoneDelay = 2 * FftStages * ButterfliesPerStage + 2;

    typedef enum logic [2:0] {WAIT, CLEAR, READ, WRITE, DONE} state_t;

    state_t                state;
    state_t                nextState;
    logic [StageWidth-1:0] stage;
    logic [FlyWidth-1:0]   fly;
    logic [FlyWidth-1:0]   twiddleMask;

    // Rotate a bin address left by the stage index
    function automatic logic [AddrWidth-1:0] rotateLeft(
        input logic [AddrWidth-1:0]  value,
        input logic [StageWidth-1:0] amount
    );
        logic [2*AddrWidth-1:0] doubled;
        doubled = {value, value} << amount;
        return doubled[2*AddrWidth-1:AddrWidth];
    endfunction

    //////////////////////////////////////////////////
    // State and loop indices
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= WAIT;
            stage <= '0;
            fly   <= '0;
        end else begin
            state <= nextState;
            if (state == CLEAR) begin
                stage <= '0;
                fly   <= '0;
            end else if (state == WRITE) begin
                // Indices only move once the pair is written
                if (fly == LastFly) begin
                    fly   <= '0;
                    stage <= stage + 1'b1;
                end else begin
                    fly <= fly + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (state)
            WAIT:    nextState = start ? CLEAR : WAIT;
            CLEAR:   nextState = READ;
            READ:    nextState = WRITE;
            WRITE:   nextState = (stage == LastStageIdx && fly == LastFly) ? DONE : READ;
            DONE:    nextState = WAIT;
            default: nextState = WAIT;
        endcase
    end

    //////////////////////////////////////////////////
    // Addresses and strobes
    //////////////////////////////////////////////////

    // Even and odd partners of twice the butterfly index
    assign addrs.a = rotateLeft({fly, 1'b0}, stage);
    assign addrs.b = rotateLeft({fly, 1'b1}, stage);

    // Stage s keeps the top s bits of the butterfly index
    assign twiddleMask = {FlyWidth{1'b1}} << (LastStageIdx - stage);
    assign twiddleAddr = {1'b0, fly & twiddleMask};

    // Even stages read bank 0 and write bank 1
    assign bankSel   = stage[0];
    assign writeEn   = (state == WRITE);
    assign lastStage = (state == WRITE) && (stage == LastStageIdx);
    assign clear     = (state == CLEAR);
    assign done      = (state == DONE);

    // An accepted start yields the result after all stages and butterflies
    assert property (@(posedge clk) disable iff (reset)
        (start && state == WAIT) |-> ##DoneDelay done);

endmodule

//--- pingPongMemory.sv
//////////////////////////////////////////////////
// Two complex banks, each with two registered ports
// Loads land in bank 0 bit-reversed, reads lag by a cycle
// Last-stage writes store zeros
//////////////////////////////////////////////////
`timescale 1ns/10ps

module pingPongMemory
    import fftPkg::*;
(
    input  logic                 clk,
    input  logic                 loadWrite,
    input  logic                 writeEn,
    input  logic                 bankSel,
    input  logic                 lastStage,
    input  logic [AddrWidth-1:0] loadAddr,
    input  complex_t             loadData,
    input  complex_t             writeA,
    input  complex_t             writeB,
    input  addrPair_t            addrs,
    output complex_t             readA,
    output complex_t             readB
);

    localparam int Banks = 2;

    logic [AddrWidth-1:0] loadAddrRev;
    complex_t             fftDataA;
    complex_t             fftDataB;

    // Per-bank port controls
    logic                 bankWe     [Banks];
    logic                 portWeA    [Banks];
    logic [AddrWidth-1:0] portAddrA  [Banks];
    complex_t             portDataA  [Banks];
    complex_t             bankQa     [Banks];
    complex_t             bankQb     [Banks];

    // Bit-reversed load order for DIT input
    assign loadAddrRev = {<<{loadAddr}};

    // Results of the last stage are only observed, the bank is left zeroed
    assign fftDataA = lastStage ? '0 : writeA;
    assign fftDataB = lastStage ? '0 : writeB;

    //////////////////////////////////////////////////
    // Bank steering
    //////////////////////////////////////////////////

    always_comb begin
        // Write to the bank that is not being read
        bankWe[0] = writeEn & bankSel;
        bankWe[1] = writeEn & ~bankSel;
        for (int i = 0; i < Banks; i++) begin
            portWeA[i]   = bankWe[i];
            portAddrA[i] = addrs.a;
            portDataA[i] = fftDataA;
        end
        // Sample loads share port A of bank 0
        if (loadWrite) begin
            portWeA[0]   = 1'b1;
            portAddrA[0] = loadAddrRev;
            portDataA[0] = loadData;
        end
    end

    for (genvar g = 0; g < Banks; g++) begin : genBank
        complex_t store [FftPoints];

        // Dual port, write-through on both ports
        always_ff @(posedge clk) begin
            if (portWeA[g]) begin
                store[portAddrA[g]] <= portDataA[g];
                bankQa[g]           <= portDataA[g];
            end else begin
                bankQa[g] <= store[portAddrA[g]];
            end
            if (bankWe[g]) begin
                store[addrs.b] <= fftDataB;
                bankQb[g]      <= fftDataB;
            end else begin
                bankQb[g] <= store[addrs.b];
            end
        end
    end

    // Read side follows the stage parity
    assign readA = bankSel ? bankQa[1] : bankQa[0];
    assign readB = bankSel ? bankQb[1] : bankQb[0];

    // Loads and transform writes must not meet on bank 0 port A
    assert property (@(posedge clk) !(loadWrite && writeEn));

endmodule

//--- butterflyUnit.sv
//////////////////////////////////////////////////
// Combinational radix-2 butterfly with twiddle ROM
// No saturation, results wrap on overflow
//////////////////////////////////////////////////
`timescale 1ns/10ps

module butterflyUnit
    import fftPkg::*;
(
    input  complex_t             readA,
    input  complex_t             readB,
    input  logic [AddrWidth-1:0] twiddleAddr,
    output complex_t             writeA,
    output complex_t             writeB
);

    // Twiddle ROM, cosines at 0 to 15 and sines at 16 to 31
    sample_t twiddleRom [FftPoints];

    logic [AddrWidth-1:0]           imagAddr;
    sample_t                        wRe;
    sample_t                        wIm;
    logic signed [ProductWidth-1:0] prodRe;
    logic signed [ProductWidth-1:0] prodIm;
    sample_t                        scaledRe;
    sample_t                        scaledIm;

    initial begin
        $readmemh(TwiddleFile, twiddleRom);
    end

    // Imaginary half sits one half-table above
    assign imagAddr = twiddleAddr + AddrWidth'(ButterfliesPerStage);
    assign wRe      = twiddleRom[twiddleAddr];
    assign wIm      = twiddleRom[imagAddr];

    // B times W
    assign prodRe = readB.re * wRe - readB.im * wIm;
    assign prodIm = readB.im * wRe + readB.re * wIm;

    // Back to the sample format
    assign scaledRe = sample_t'(prodRe[ProductLsb +: SampleWidth]);
    assign scaledIm = sample_t'(prodIm[ProductLsb +: SampleWidth]);

    // Sum and difference outputs
    assign writeA.re = readA.re + scaledRe;
    assign writeA.im = readA.im + scaledIm;
    assign writeB.re = readA.re - scaledRe;
    assign writeB.im = readA.im - scaledIm;

endmodule

//--- peakFinder.sv
//////////////////////////////////////////////////
// Strongest-bin search over the last FFT stage
// Ties keep the lower bin, display holds until the next done
//////////////////////////////////////////////////
`timescale 1ns/10ps

module peakFinder
    import fftPkg::*;
    import capturePkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 lastStage,
    input  logic                 clear,
    input  logic                 done,
    input  logic [AddrWidth-1:0] binAddr,
    input  complex_t             value,
    output logic [LedCount-1:0]  leds
);

    // Sum of two full-scale squares needs one extra bit
    localparam int PowerWidth = 2 * SampleWidth + 1;

    logic signed [PowerWidth-1:0] power;
    logic signed [PowerWidth-1:0] bestPower;
    logic [AddrWidth-1:0]         bestAddr;
    logic [LedBinWidth-1:0]       binReg;

    // Squared magnitude
    assign power = value.re * value.re + value.im * value.im;

    // Running maximum
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bestPower <= '0;
            bestAddr  <= '0;
        end else if (clear) begin
            bestPower <= '0;
            bestAddr  <= '0;
        end else if (lastStage && power > bestPower) begin
            bestPower <= power;
            bestAddr  <= binAddr;
        end
    end

    // Displayed bin
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            binReg <= '0;
        end else if (done) begin
            binReg <= bestAddr[LedBinWidth-1:0];
        end
    end

    // One-hot decode
    assign leds = LedCount'(1) << binReg;

    // Last-stage A addresses from the sequencer stay in the lower half
    assert property (@(posedge clk) disable iff (reset)
        done |-> (bestAddr < AddrWidth'(LedCount)));

endmodule

//--- toneAnalyzer.sv
//////////////////////////////////////////////////
// Square-wave tone analyzer, single clock domain
// Shows the strongest of bins 0 to 15 one-hot on leds
//////////////////////////////////////////////////
`timescale 1ns/10ps

module toneAnalyzer
    import fftPkg::*;
    import capturePkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                data,
    output logic                done,
    output logic [LedCount-1:0] leds
);

    // Capture to memory
    logic                 loadWrite;
    logic                 start;
    logic [AddrWidth-1:0] loadAddr;
    complex_t             loadData;

    // Sequencer controls
    addrPair_t            addrs;
    logic [AddrWidth-1:0] twiddleAddr;
    logic                 writeEn;
    logic                 bankSel;
    logic                 lastStage;
    logic                 clear;

    // Datapath
    complex_t             readA;
    complex_t             readB;
    complex_t             writeA;
    complex_t             writeB;

    sampleCounter i_sampleCounter (
        .clk(clk), .reset(reset), .data(data), .done(done),
        .loadWrite(loadWrite), .start(start), .loadAddr(loadAddr), .loadData(loadData)
    );

    fftSequencer i_fftSequencer (
        .clk(clk), .reset(reset), .start(start), .addrs(addrs), .twiddleAddr(twiddleAddr),
        .writeEn(writeEn), .bankSel(bankSel), .lastStage(lastStage), .clear(clear),
        .done(done)
    );

    pingPongMemory i_pingPongMemory (
        .clk(clk), .loadWrite(loadWrite), .writeEn(writeEn), .bankSel(bankSel),
        .lastStage(lastStage), .loadAddr(loadAddr), .loadData(loadData),
        .writeA(writeA), .writeB(writeB), .addrs(addrs), .readA(readA), .readB(readB)
    );

    butterflyUnit i_butterflyUnit (
        .readA(readA), .readB(readB), .twiddleAddr(twiddleAddr),
        .writeA(writeA), .writeB(writeB)
    );

    // Peak search watches the A output of the final stage
    peakFinder i_peakFinder (
        .clk(clk), .reset(reset), .lastStage(lastStage), .clear(clear), .done(done),
        .binAddr(addrs.a), .value(writeA), .leds(leds)
    );

endmodule

//--- tbToneAnalyzer.sv
//////////////////////////////////////////////////
// Directed tests for the tone analyzer
// Tones hold each level a whole number of sample periods
// Only the second result after a tone change is checked
//////////////////////////////////////////////////
`timescale 1ns/10ps

module tbToneAnalyzer
    import fftPkg::*;
    import capturePkg::*;
();

    localparam int ClkPeriod   = 4;
    localparam int ResetCycles = 5;
    // 32 loads, the start strobe and the transform
    localparam int FrameCycles = 33 * SamplePeriod + 162;
    localparam int FrameMargin = 4 * SamplePeriod;
    // Each tone run waits for two results
    localparam int FramesDc       = 2;
    localparam int FramesSquare   = 4 * 2;
    localparam int FramesTiming   = 2;
    localparam int FramesRandom   = 8 * 2;
    localparam int FramesTotal    = FramesDc + FramesSquare + FramesTiming + FramesRandom;
    localparam int WatchdogCycles = FramesTotal * (FrameCycles + FrameMargin) + ResetCycles;
    localparam int ToneCycleLimit = 3 * (FrameCycles + FrameMargin);

    logic                clk;
    logic                reset;
    logic                data;
    logic                done;
    logic [LedCount-1:0] leds;

    int errorCount;
    int testsRun;
    int testsFailed;
    int ledChanges;
    int seed = 12;

    toneAnalyzer i_toneAnalyzer (
        .clk(clk), .reset(reset), .data(data), .done(done), .leds(leds)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Expected display, only the bit of the bin is lit
    function automatic logic [LedCount-1:0] binLeds(input int bin);
        logic [LedCount-1:0] pattern;
        pattern      = '0;
        pattern[bin] = 1'b1;
        return pattern;
    endfunction

    task automatic compareLeds(input string what, input logic [LedCount-1:0] expected);
        if (leds !== expected) begin
            $display("ERROR at %t: %s, leds %h, expected %h", $time, what, leds, expected);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testsRun++;
        if (errorCount == errorsBefore) begin
            $display("%s: passed", name);
        end else begin
            testsFailed++;
            $display("%s: failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    //////////////////////////////////////////////////
    // Tone driver
    //////////////////////////////////////////////////

    // k cycles per 32 samples, k of 0 holds startLevel
    // Returns at the negedge after the second result is shown
    task automatic runTone(input int k, input logic startLevel, input bit watchTiming);
        int                  halfCycles;
        int                  phase;
        int                  cycles;
        int                  dones;
        bit                  settled;
        logic                level;
        logic                prevDone;
        logic [LedCount-1:0] prevLeds;
        halfCycles = (k == 0) ? 0 : (FftPoints / (2 * k)) * SamplePeriod;
        level      = startLevel;
        phase      = 0;
        cycles     = 0;
        dones      = 0;
        settled    = 1'b0;
        @(posedge clk);
        data <= level;
        @(negedge clk);
        prevDone = done;
        prevLeds = leds;
        while (!settled && cycles < ToneCycleLimit) begin
            @(posedge clk);
            cycles++;
            if (halfCycles != 0) begin
                phase++;
                if (phase == halfCycles) begin
                    phase = 0;
                    level = ~level;
                    data <= level;
                end
            end
            @(negedge clk);
            if (watchTiming) begin
                if (done && prevDone) begin
                    $display("ERROR at %t: done high for a second cycle", $time);
                    errorCount++;
                end
                if (leds !== prevLeds && !prevDone) begin
                    $display("ERROR at %t: leds changed from %h to %h without done",
                             $time, prevLeds, leds);
                    errorCount++;
                end
                if (leds !== prevLeds) begin
                    ledChanges++;
                end
            end
            // Display updates on the edge that ends the done cycle
            if (prevDone && dones == 2) begin
                settled = 1'b1;
            end
            if (done) begin
                dones++;
            end
            prevDone = done;
            prevLeds = leds;
        end
        if (!settled) begin
            $display("No second done pulse within %0d cycles for tone k=%0d", cycles, k);
            errorCount++;
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic resetDefaults();
        int errorsBefore;
        errorsBefore = errorCount;
        @(negedge clk);
        if (done !== 1'b0) begin
            $display("ERROR at %t: done is %b after reset", $time, done);
            errorCount++;
        end
        compareLeds("after reset", binLeds(0));
        reportTest("reset state", errorsBefore);
    endtask

    task automatic dcToneBin();
        int errorsBefore;
        errorsBefore = errorCount;
        runTone(0, 1'b1, 1'b0);
        compareLeds("data held high", binLeds(0));
        reportTest("dc input", errorsBefore);
    endtask

    task automatic squareToneBins();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int k = 1; k <= 8; k = k * 2) begin
            runTone(k, 1'b1, 1'b0);
            compareLeds($sformatf("square wave k=%0d", k), binLeds(k));
        end
        reportTest("square waves", errorsBefore);
    endtask

    // Previous test leaves bin 8, so the display must move to bin 2
    task automatic doneAndLedTiming();
        int errorsBefore;
        errorsBefore = errorCount;
        ledChanges   = 0;
        runTone(2, 1'b0, 1'b1);
        if (ledChanges == 0) begin
            $display("The leds never changed while the tone moved from bin 8 to bin 2");
            errorCount++;
        end
        compareLeds("timing run k=2", binLeds(2));
        reportTest("done pulse and led timing", errorsBefore);
    endtask

    task automatic randomToneBins();
        int   errorsBefore;
        int   pick;
        int   levelPick;
        int   k;
        logic level;
        errorsBefore = errorCount;
        for (int run = 0; run < 8; run++) begin
            pick      = $random(seed);
            levelPick = $random(seed);
            k         = 1 << (pick & 3);
            level     = levelPick[0];
            runTone(k, level, 1'b0);
            compareLeds($sformatf("random run %0d k=%0d", run, k), binLeds(k));
        end
        reportTest("random tones", errorsBefore);
    endtask

    //////////////////////////////////////////////////
    // Sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        $timeformat(-9, 0, " ns", 0);
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        ledChanges  = 0;
        reset       = 1'b1;
        data        = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        reset <= 1'b0;
        resetDefaults();
        dcToneBin();
        squareToneBins();
        doneAndLedTiming();
        randomToneBins();
        $display("Tests run %0d, failed %0d, check errors %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Run timed out after %0d cycles before all tests finished", WatchdogCycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- twiddleTable.hex
// Q1.15 cosines for k = 0 to 15, then negated sines for k = 0 to 15
7FFF
7D89
7641
6A6D
5A82
471C
30FB
18F9
0000
E707
CF05
B8E4
A57E
9593
89BF
8277
0000
E707
CF05
B8E4
A57E
9593
89BF
8277
8001
8277
89BF
9593
A57E
B8E4
CF05
E707

//--- flist.f
fftPkg.sv
capturePkg.sv
sampleCounter.sv
fftSequencer.sv
pingPongMemory.sv
butterflyUnit.sv
peakFinder.sv
toneAnalyzer.sv
tbToneAnalyzer.sv

//--- Makefile
# Verilator build and run of the tone analyzer testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tbToneAnalyzer
FLIST     := flist.f
OBJDIR    := obj_dir
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: $(BIN) twiddleTable.hex
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^RESULT: PASS$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
